// ==== verilog/muldiv_pkg.sv ====
// M-extension shared definitions
`default_nettype none

package muldiv_pkg;

  ////////////////////
  // widths
  ////////////////////

  // operand and result width of RV32
  localparam int unsigned Xlen = 32;
  localparam int unsigned XlenLog2 = $clog2(Xlen);

  ////////////////////
  // instruction fields
  ////////////////////

  // R-type OP major opcode
  localparam logic [6:0] OpcodeOp = 7'b0110011;
  // funct7 that selects the M extension within OP
  localparam logic [6:0] Funct7MulDiv = 7'b0000001;

  // funct3 codes of the M extension
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } muldiv_op_e;

  // divide class goes to the serial divider
  function automatic logic is_div_op(muldiv_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

endpackage

`default_nettype wire

// ==== verilog/leading_zero_counter.sv ====
// leading zero counter
`timescale 1ns/10ps
`default_nettype none

module leading_zero_counter import muldiv_pkg::*; (
  input  logic [Xlen-1:0]     in_i,
  output logic [XlenLog2-1:0] count_o,
  output logic                zero_o
);

  logic found;

  // priority search, first one seen from the msb wins
  always_comb begin
    found   = 1'b0;
    count_o = '0;
    for (int i = Xlen - 1; i >= 0; i--) begin
      if (!found && in_i[i]) begin
        found   = 1'b1;
        count_o = XlenLog2'(Xlen - 1 - i);
      end
    end
  end

  // count is meaningless here, callers check this flag
  assign zero_o = ~found;

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
// single-stage multiplier
`timescale 1ns/10ps
`default_nettype none

module mul_unit import muldiv_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  output logic               ready_o,
  input  muldiv_op_e         op_i,
  input  logic [Xlen-1:0]    operand_a_i,
  input  logic [Xlen-1:0]    operand_b_i,
  input  logic [IdWidth-1:0] id_i,
  output logic               valid_o,
  input  logic               ready_i,
  output logic [Xlen-1:0]    result_o,
  output logic [IdWidth-1:0] id_o
);

  logic                     sign_a;
  logic                     sign_b;
  logic                     select_upper;
  logic signed [Xlen:0]     operand_a_ext;
  logic signed [Xlen:0]     operand_b_ext;
  logic signed [2*Xlen-1:0] product;
  logic                     accept;

  logic                     valid_q;
  logic                     select_upper_q;
  logic [2*Xlen-1:0]        product_q;
  logic [IdWidth-1:0]       id_q;

  // operand signedness per operation
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    unique case (op_i)
      MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      MULHSU: sign_a = 1'b1;
      default: ;
    endcase
  end

  // only MUL keeps the low word
  assign select_upper = (op_i != MUL);

  // one extra bit turns every form into a signed multiply
  assign operand_a_ext = {sign_a & operand_a_i[Xlen-1], operand_a_i};
  assign operand_b_ext = {sign_b & operand_b_i[Xlen-1], operand_b_i};
  assign product       = operand_a_ext * operand_b_ext;

  // accept while empty or while the held result leaves
  assign ready_o = ~valid_q | ready_i;
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      product_q      <= product;
      select_upper_q <= select_upper;
      id_q           <= id_i;
    end
  end

  assign valid_o  = valid_q;
  assign id_o     = id_q;
  assign result_o = select_upper_q ? product_q[2*Xlen-1:Xlen] : product_q[Xlen-1:0];

endmodule

`default_nettype wire

// ==== verilog/serial_divider.sv ====
// serial divider
`timescale 1ns/10ps
`default_nettype none

module serial_divider import muldiv_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  muldiv_op_e         op_i,
  input  logic [Xlen-1:0]    op_a_i,
  input  logic [Xlen-1:0]    op_b_i,
  input  logic [IdWidth-1:0] id_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output logic [Xlen-1:0]    result_o,
  output logic [IdWidth-1:0] id_o
);

  localparam int unsigned CntWidth   = $clog2(Xlen + 1);
  localparam int unsigned ShiftWidth = CntWidth + 1;

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                  signed_op;
  logic                  rem_op;
  logic                  a_sign;
  logic                  b_sign;
  logic                  b_zero;
  logic [Xlen-1:0]       lzc_a_in;
  logic [Xlen-1:0]       lzc_b_in;
  logic [XlenLog2-1:0]   lzc_a_count;
  logic [XlenLog2-1:0]   lzc_b_count;
  logic                  lzc_a_zero;
  logic                  lzc_b_zero;
  logic [CntWidth-1:0]   shift_a;
  logic [ShiftWidth-1:0] div_shift;
  logic [Xlen-1:0]       b_aligned;
  logic [Xlen-1:0]       a_load;

  logic                  load_en;
  logic                  shift_en;
  logic                  ab_comp;
  logic                  cnt_zero;
  logic [Xlen-1:0]       out_mux;

  logic [Xlen-1:0]       op_a_q;
  logic [Xlen-1:0]       op_b_q;
  logic [Xlen-1:0]       res_q;
  logic [IdWidth-1:0]    id_q;
  logic [CntWidth-1:0]   cnt_q;
  logic                  rem_sel_q;
  logic                  comp_inv_q;
  logic                  res_inv_q;
  logic                  b_zero_q;
  logic                  res_zero_q;

  assign signed_op = op_i inside {DIV, REM};
  assign rem_op    = op_i inside {REM, REMU};
  assign a_sign    = op_a_i[Xlen-1];
  assign b_sign    = op_b_i[Xlen-1];
  assign b_zero    = (op_b_i == '0);

  ////////////////////
  // operand alignment
  ////////////////////

  // one's complement approximates the magnitude, the shift keeps it conservative
  assign lzc_a_in = (signed_op & a_sign) ? {~op_a_i[Xlen-2:0], 1'b0} : op_a_i;
  assign lzc_b_in = (signed_op & b_sign) ? ~op_b_i : op_b_i;

  leading_zero_counter lzc_a_inst (
    .in_i    (lzc_a_in),
    .count_o (lzc_a_count),
    .zero_o  (lzc_a_zero)
  );

  leading_zero_counter lzc_b_inst (
    .in_i    (lzc_b_in),
    .count_o (lzc_b_count),
    .zero_o  (lzc_b_zero)
  );

  assign shift_a   = lzc_a_zero ? CntWidth'(Xlen) : CntWidth'(lzc_a_count);
  // negative shift means |b| > |a| and the quotient is zero
  assign div_shift = lzc_b_zero ? ShiftWidth'(Xlen) :
                     ShiftWidth'(lzc_b_count) - ShiftWidth'(shift_a);
  assign b_aligned = op_b_i << div_shift[CntWidth-1:0];

  // remainder register carries the divisor's sign during the loop
  assign a_load = (signed_op & (a_sign ^ b_sign)) ? -op_a_i : op_a_i;

  ////////////////////
  // datapath
  ////////////////////

  // magnitude compare, inverted when both sides are negative
  assign ab_comp  = ((op_a_q == op_b_q) | ((op_a_q > op_b_q) ^ comp_inv_q)) &
                    ((|op_a_q) | b_zero_q);
  assign cnt_zero = (cnt_q == '0);
  assign out_mux  = rem_sel_q ? op_a_q : res_q;
  assign result_o = res_inv_q ? -out_mux : out_mux;
  assign id_o     = id_q;

  ////////////////////
  // control FSM
  ////////////////////

  always_comb begin
    state_d     = state_q;
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    load_en     = 1'b0;
    shift_en    = 1'b0;
    unique case (state_q)
      IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          load_en = 1'b1;
          state_d = DIVIDE;
        end
      end
      DIVIDE: begin
        if (res_zero_q) begin
          // early exit, remainder is the dividend
          out_valid_o = 1'b1;
          state_d     = out_ready_i ? IDLE : FINISH;
        end else begin
          shift_en = 1'b1;
          if (cnt_zero) begin
            state_d = FINISH;
          end
        end
      end
      FINISH: begin
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      rem_sel_q  <= 1'b0;
      comp_inv_q <= 1'b0;
      res_inv_q  <= 1'b0;
      b_zero_q   <= 1'b0;
      res_zero_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_en) begin
        cnt_q      <= div_shift[CntWidth-1:0];
        rem_sel_q  <= rem_op;
        comp_inv_q <= signed_op & b_sign;
        b_zero_q   <= b_zero;
        // division by zero keeps the all-ones quotient
        res_inv_q  <= (~b_zero | rem_op) & signed_op & (a_sign ^ b_sign);
        res_zero_q <= div_shift[ShiftWidth-1];
      end else if (shift_en && !cnt_zero) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // working registers, one quotient bit per cycle
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      op_a_q <= a_load;
      op_b_q <= b_aligned;
      res_q  <= '0;
      id_q   <= id_i;
    end else if (shift_en) begin
      if (ab_comp) begin
        op_a_q <= op_a_q - op_b_q;
      end
      // arithmetic shift for a negative divisor
      op_b_q <= {comp_inv_q, op_b_q[Xlen-1:1]};
      res_q  <= {res_q[Xlen-2:0], ab_comp};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/result_arbiter.sv ====
// round-robin response arbiter
`timescale 1ns/10ps
`default_nettype none

module result_arbiter #(
  parameter type         payload_t = logic,
  parameter int unsigned NumInputs = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NumInputs-1:0] in_valid_i,
  output logic [NumInputs-1:0] in_ready_o,
  input  payload_t             in_payload_i [NumInputs],
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output payload_t             out_payload_o
);

  localparam int unsigned IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

  logic [IdxWidth-1:0] prio_q;
  logic                lock_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic [IdxWidth-1:0] rr_idx;
  logic                rr_found;
  logic [IdxWidth-1:0] gnt_idx;
  logic [IdxWidth-1:0] next_prio;

  // first valid input at or after the priority pointer
  always_comb begin
    int unsigned idx;
    rr_idx   = '0;
    rr_found = 1'b0;
    for (int unsigned off = 0; off < NumInputs; off++) begin
      idx = prio_q + off;
      if (idx >= NumInputs) begin
        idx = idx - NumInputs;
      end
      if (!rr_found && in_valid_i[idx]) begin
        rr_found = 1'b1;
        rr_idx   = IdxWidth'(idx);
      end
    end
  end

  // a stalled grant stays put until it is taken
  assign gnt_idx       = lock_q ? lock_idx_q : rr_idx;
  assign out_valid_o   = lock_q ? in_valid_i[lock_idx_q] : rr_found;
  assign out_payload_o = in_payload_i[gnt_idx];
  assign next_prio     = (gnt_idx == IdxWidth'(NumInputs - 1)) ? '0 : gnt_idx + 1'b1;

  always_comb begin
    for (int unsigned i = 0; i < NumInputs; i++) begin
      in_ready_o[i] = out_ready_i & out_valid_o & (gnt_idx == IdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      lock_q <= 1'b0;
      prio_q <= next_prio;
    end else if (out_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/shared_muldiv.sv ====
// shared M-extension unit
`timescale 1ns/10ps
`default_nettype none

module shared_muldiv import muldiv_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // request port
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic [31:0]        req_instr_i,
  input  logic [Xlen-1:0]    req_op_a_i,
  input  logic [Xlen-1:0]    req_op_b_i,
  input  logic [IdWidth-1:0] req_id_i,
  // response port
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output logic [Xlen-1:0]    resp_data_o,
  output logic [IdWidth-1:0] resp_id_o,
  output logic               resp_error_o
);

  typedef struct packed {
    logic [Xlen-1:0]    data;
    logic [IdWidth-1:0] id;
    logic               error;
  } resp_t;

  // arbiter slots: 0 divider, 1 multiplier, 2 error
  localparam int unsigned NumSources = 3;

  logic                  is_muldiv;
  muldiv_op_e            req_op;
  logic                  mul_valid_in;
  logic                  mul_ready_in;
  logic                  div_valid_in;
  logic                  div_ready_in;
  logic                  mul_valid;
  logic                  div_valid;
  logic [Xlen-1:0]       mul_result;
  logic [Xlen-1:0]       div_result;
  logic [IdWidth-1:0]    mul_id;
  logic [IdWidth-1:0]    div_id;
  logic                  err_accept;
  logic                  err_valid_q;
  logic [IdWidth-1:0]    err_id_q;
  logic [NumSources-1:0] src_valid;
  logic [NumSources-1:0] src_ready;
  resp_t                 src_payload [NumSources];
  resp_t                 resp_payload;

  ////////////////////
  // decoder
  ////////////////////

  assign is_muldiv = (req_instr_i[6:0] == OpcodeOp) && (req_instr_i[31:25] == Funct7MulDiv);
  assign req_op    = muldiv_op_e'(req_instr_i[14:12]);

  always_comb begin
    mul_valid_in = 1'b0;
    div_valid_in = 1'b0;
    if (!is_muldiv) begin
      req_ready_o = ~err_valid_q;
    end else if (is_div_op(req_op)) begin
      div_valid_in = req_valid_i;
      req_ready_o  = div_ready_in;
    end else begin
      mul_valid_in = req_valid_i;
      req_ready_o  = mul_ready_in;
    end
  end

  // illegal instruction slot
  assign err_accept = req_valid_i & ~is_muldiv & ~err_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_accept) begin
      err_valid_q <= 1'b1;
    end else if (src_ready[2]) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept) begin
      err_id_q <= req_id_i;
    end
  end

  ////////////////////
  // units
  ////////////////////

  mul_unit #(
    .IdWidth (IdWidth)
  ) mul_unit_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (mul_valid_in),
    .ready_o     (mul_ready_in),
    .op_i        (req_op),
    .operand_a_i (req_op_a_i),
    .operand_b_i (req_op_b_i),
    .id_i        (req_id_i),
    .valid_o     (mul_valid),
    .ready_i     (src_ready[1]),
    .result_o    (mul_result),
    .id_o        (mul_id)
  );

  serial_divider #(
    .IdWidth (IdWidth)
  ) serial_divider_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (div_valid_in),
    .in_ready_o  (div_ready_in),
    .op_i        (req_op),
    .op_a_i      (req_op_a_i),
    .op_b_i      (req_op_b_i),
    .id_i        (req_id_i),
    .out_valid_o (div_valid),
    .out_ready_i (src_ready[0]),
    .result_o    (div_result),
    .id_o        (div_id)
  );

  ////////////////////
  // response path
  ////////////////////

  assign src_valid      = {err_valid_q, mul_valid, div_valid};
  assign src_payload[0] = '{data: div_result, id: div_id, error: 1'b0};
  assign src_payload[1] = '{data: mul_result, id: mul_id, error: 1'b0};
  assign src_payload[2] = '{data: '0, id: err_id_q, error: 1'b1};

  result_arbiter #(
    .payload_t (resp_t),
    .NumInputs (NumSources)
  ) result_arbiter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (src_valid),
    .in_ready_o    (src_ready),
    .in_payload_i  (src_payload),
    .out_valid_o   (resp_valid_o),
    .out_ready_i   (resp_ready_i),
    .out_payload_o (resp_payload)
  );

  assign resp_data_o  = resp_payload.data;
  assign resp_id_o    = resp_payload.id;
  assign resp_error_o = resp_payload.error;

endmodule

`default_nettype wire

// ==== tb/shared_muldiv_tb.sv ====
// shared M-extension unit testbench
`timescale 1ns/10ps
`default_nettype none

module shared_muldiv_tb;

  localparam int unsigned IdWidth = 5;
  localparam int MaxVectors = 2 ** IdWidth;
  localparam int IssueTimeout = 200;
  localparam int DrainTimeout = 2000;
  localparam logic [31:0] LfsrSeed = 32'h7e8d15df;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               req_valid_i;
  logic               req_ready_o;
  logic [31:0]        req_instr_i;
  logic [31:0]        req_op_a_i;
  logic [31:0]        req_op_b_i;
  logic [IdWidth-1:0] req_id_i;
  logic               resp_valid_o;
  logic               resp_ready_i;
  logic [31:0]        resp_data_o;
  logic [IdWidth-1:0] resp_id_o;
  logic               resp_error_o;

  // vectors, the id of a request is its line index
  logic [31:0] vec_instr    [MaxVectors];
  logic [31:0] vec_op_a     [MaxVectors];
  logic [31:0] vec_op_b     [MaxVectors];
  logic [31:0] vec_expected [MaxVectors];
  int          num_vectors;

  // request side state
  logic        issued    [MaxVectors];
  logic        must_beat [MaxVectors];
  int          beat_id   [MaxVectors];
  logic        long_div_valid;
  int          long_div_id;
  int          run_failures;
  logic [31:0] idle_lfsr;

  // response side state
  logic        returned [MaxVectors];
  int          return_count;
  int          error_count;
  int          test_count;
  logic [31:0] ready_lfsr;

  shared_muldiv #(
    .IdWidth (IdWidth)
  ) shared_muldiv_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_instr_i  (req_instr_i),
    .req_op_a_i   (req_op_a_i),
    .req_op_b_i   (req_op_b_i),
    .req_id_i     (req_id_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o),
    .resp_id_o    (resp_id_o),
    .resp_error_o (resp_error_o)
  );

  always #2 clk_i = ~clk_i;

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // OP opcode with funct7 0000001
  function automatic logic is_m_instr(input logic [31:0] instr);
    return (instr[6:0] == 7'b0110011) && (instr[31:25] == 7'b0000001);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    test_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic read_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] instr;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] expected;
    num_vectors = 0;
    fd = $fopen("tb/muldiv_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      run_failures++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h", instr, op_a, op_b, expected);
          if (fields == 4 && num_vectors < MaxVectors) begin
            vec_instr[num_vectors]    = instr;
            vec_op_a[num_vectors]     = op_a;
            vec_op_b[num_vectors]     = op_b;
            vec_expected[num_vectors] = expected;
            num_vectors++;
          end else if (fields == 4) begin
            $display("more vectors in the data file than there are ids");
            run_failures++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_vectors == 0) begin
      $display("the data file holds no vectors");
      run_failures++;
    end
  endtask

  // bookkeeping at the cycle a request transfers
  task automatic note_issue(input int idx);
    logic legal;
    legal       = is_m_instr(vec_instr[idx]);
    issued[idx] = 1'b1;
    // a multiply behind a running division by zero must overtake it
    if (legal && !vec_instr[idx][14] && long_div_valid && !returned[long_div_id]) begin
      must_beat[idx] = 1'b1;
      beat_id[idx]   = long_div_id;
    end
    // division by zero runs all 32 quotient bits
    if (legal && vec_instr[idx][14] && vec_op_b[idx] == '0) begin
      long_div_valid = 1'b1;
      long_div_id    = idx;
    end
  endtask

  // called just after a falling edge
  task automatic issue_request(input int idx);
    int   wait_cycles;
    logic accepted;
    logic idle_after;
    wait_cycles = 0;
    accepted    = 1'b0;
    idle_after  = 1'b0;
    req_valid_i = 1'b1;
    req_instr_i = vec_instr[idx];
    req_op_a_i  = vec_op_a[idx];
    req_op_b_i  = vec_op_b[idx];
    req_id_i    = IdWidth'(idx);
    while (!accepted && run_failures == 0) begin
      #1;
      if (req_ready_o) begin
        accepted = 1'b1;
        note_issue(idx);
        idle_lfsr  = lfsr_next(idle_lfsr);
        idle_after = idle_lfsr[0];
      end else if (wait_cycles == IssueTimeout) begin
        $display("request %0d was not accepted within %0d cycles", idx, IssueTimeout);
        run_failures++;
      end
      wait_cycles++;
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
    if (idle_after) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_response();
    int id;
    id = int'(resp_id_o);
    if (!issued[id] || returned[id]) begin
      $display("a response came back with id %0d, which is not outstanding", id);
      error_count++;
    end else begin
      returned[id] = 1'b1;
      return_count++;
      check_value($sformatf("vector %0d data", id), vec_expected[id], resp_data_o);
      check_value($sformatf("vector %0d error flag", id),
                  32'(!is_m_instr(vec_instr[id])), 32'(resp_error_o));
      if (must_beat[id]) begin
        check_value($sformatf("vector %0d ahead of division %0d", id, beat_id[id]),
                    32'(1), 32'(!returned[beat_id[id]]));
      end
    end
  endtask

  ////////////////////
  // response side
  ////////////////////

  initial begin : response_monitor
    resp_ready_i = 1'b0;
    ready_lfsr   = LfsrSeed;
    return_count = 0;
    error_count  = 0;
    test_count   = 0;
    for (int i = 0; i < MaxVectors; i++) begin
      returned[i] = 1'b0;
    end
    forever begin
      @(negedge clk_i);
      ready_lfsr   = lfsr_next(ready_lfsr);
      resp_ready_i = ready_lfsr[0];
      // sample before the request side looks at the same edge
      #0.5;
      if (resp_valid_o && resp_ready_i) begin
        check_response();
      end
    end
  end

  ////////////////////
  // request side
  ////////////////////

  initial begin : stimulus
    int drain_cycles;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_instr_i    = '0;
    req_op_a_i     = '0;
    req_op_b_i     = '0;
    req_id_i       = '0;
    idle_lfsr      = LfsrSeed;
    run_failures   = 0;
    long_div_valid = 1'b0;
    long_div_id    = 0;
    for (int i = 0; i < MaxVectors; i++) begin
      issued[i]    = 1'b0;
      must_beat[i] = 1'b0;
      beat_id[i]   = 0;
    end
    read_vectors();

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int i = 0; i < num_vectors && run_failures == 0; i++) begin
      issue_request(i);
    end

    // every id has to come back once
    drain_cycles = 0;
    while (run_failures == 0 && return_count < num_vectors) begin
      if (drain_cycles == DrainTimeout) begin
        $display("only %0d of %0d responses returned within %0d cycles",
                 return_count, num_vectors, DrainTimeout);
        run_failures++;
      end else begin
        @(negedge clk_i);
        drain_cycles++;
      end
    end
    // catch stray responses
    repeat (4) @(negedge clk_i);

    $display("%0d checks, %0d errors", test_count, error_count + run_failures);
    if (error_count == 0 && run_failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/muldiv_testdata.txt ====
# instruction word, operand a, operand b, expected result, all hex
# the id of a request is its line number among the data lines, from 0
022081B3 00000007 00000006 0000002A
022081B3 FFFFFFFD 00000005 FFFFFFF1
022091B3 FFFFFFFD 00000005 FFFFFFFF
022091B3 80000000 80000000 40000000
0220A1B3 FFFFFFFF FFFFFFFF FFFFFFFF
0220A1B3 00000002 80000000 00000001
0220B1B3 FFFFFFFF FFFFFFFF FFFFFFFE
0220B1B3 12345678 00010000 00001234
0220C1B3 00000064 00000007 0000000E
0220C1B3 FFFFFF9C 00000007 FFFFFFF2
0220C1B3 00000064 FFFFFFF9 FFFFFFF2
0220C1B3 FFFFFF9C FFFFFFF9 0000000E
0220E1B3 FFFFFF9C 00000007 FFFFFFFE
0220E1B3 00000064 FFFFFFF9 00000002
0220D1B3 FFFFFFFF 00000010 0FFFFFFF
0220F1B3 FFFFFFFF 00000010 0000000F
0220D1B3 00000005 00000009 00000000
0220E1B3 00000005 00000009 00000005
0220C1B3 00000064 00000000 FFFFFFFF
022081B3 0000FFFF 0000FFFF FFFE0001
0220B1B3 80000000 00000004 00000002
002081B3 00000001 00000002 00000000
022091B3 FFFFFFFF 00000001 FFFFFFFF
0220E1B3 FFFFFF9C 00000000 FFFFFF9C
0220D1B3 12345678 00000000 FFFFFFFF
0220F1B3 12345678 00000000 12345678
0220C1B3 80000000 FFFFFFFF 80000000
0220E1B3 80000000 FFFFFFFF 00000000
00100093 00000005 00000006 00000000
00000000 00000003 00000004 00000000
022081B3 80000000 FFFFFFFF 80000000

// ==== all.f ====
verilog/muldiv_pkg.sv
verilog/leading_zero_counter.sv
verilog/mul_unit.sv
verilog/serial_divider.sv
verilog/result_arbiter.sv
verilog/shared_muldiv.sv
tb/shared_muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module shared_muldiv_tb -f all.f -o sim_shared_muldiv \
  && ./obj_dir/sim_shared_muldiv | tee sim.log \
  && grep -q "^TESTBENCH PASSED$" sim.log \
  && echo "simulation run succeeded" \
  || { echo "simulation run failed"; exit 1; }
